// File: hw/halfAccum_settings.svh
`ifndef HALFACCUM_SETTINGS_SVH
`define HALFACCUM_SETTINGS_SVH

// Half-precision word layout
`define HALF_WIDTH 16
`define EXP_WIDTH 5 // Exponent field
`define MANT_WIDTH 10 // Stored mantissa, hidden bit not counted
`define EXP_BIAS 15

// Significand including the hidden bit
`define SIG_WIDTH (`MANT_WIDTH + 1)
// Significand plus guard, round and sticky
`define ALIGN_WIDTH (`SIG_WIDTH + 3)

// Accumulation run
`define ACCUM_COUNT 8 // Words summed per start
`define ACCUM_ADDR_WIDTH 3

// Adder depth in cycles from input valid to output valid
`define FPADD_LATENCY 4

`endif

// File: hw/halfFloatPkg.sv
`default_nettype none
`include "halfAccum_settings.svh"

package halfFloatPkg;

	// Sign, biased exponent, stored mantissa
	typedef struct packed {
		logic sign;
		logic [`EXP_WIDTH-1:0] exponent;
		logic [`MANT_WIDTH-1:0] mantissa;
	} halfFields_t;

	// One word, read raw or by field
	typedef union packed {
		logic [`HALF_WIDTH-1:0] bits; // Raw view for magnitude compare
		halfFields_t fields;
	} halfWord_u;

	// Handoff from alignment half to normalize half
	typedef struct packed {
		logic sign; // Sign of larger operand
		logic effSub; // Operand signs differ
		logic [`EXP_WIDTH-1:0] exponent; // Common exponent
		logic [`SIG_WIDTH-1:0] bigSig; // Hidden bit on top
		logic [`ALIGN_WIDTH-1:0] smallSig; // Shifted, low 3 bits are G R S
	} alignedOp_t;

endpackage

`default_nettype wire

// File: hw/accumCtrlPkg.sv
`default_nettype none

package accumCtrlPkg;

	// Per element: Fetch, Capture, then Wait on the adder
	typedef enum logic [1:0] {
		stateIdle, // Waiting for ap_start
		stateFetch, // Read strobe, or finish at full count
		stateCapture, // Memory word valid, add issued
		stateWait // Add in flight
	} accumState_t;

endpackage

`default_nettype wire

// File: hw/fpAddAlign.sv
`timescale 1ns/10ps
`default_nettype none
`include "halfAccum_settings.svh"

module fpAddAlign (
	input wire ap_clk,
	input wire ap_rst,
	input wire addInValid,
	input wire halfFloatPkg::halfWord_u addOpA,
	input wire halfFloatPkg::halfWord_u addOpB,
	output logic alignValid,
	output halfFloatPkg::alignedOp_t alignedOp
);
	import halfFloatPkg::*;

	halfWord_u bigOp;
	halfWord_u smallOp;
	logic swapOps;
	logic [`EXP_WIDTH-1:0] bigExp;
	logic [`EXP_WIDTH-1:0] smallExp;

	// Stage one registers
	logic s1Valid;
	logic s1Sign;
	logic s1EffSub;
	logic [`EXP_WIDTH-1:0] s1Exp;
	logic [`EXP_WIDTH-1:0] s1Shift;
	logic [`SIG_WIDTH-1:0] s1BigSig;
	logic [`SIG_WIDTH-1:0] s1SmallSig;

	// Stage two shifter
	logic [`ALIGN_WIDTH-1:0] smallExt;
	logic [`ALIGN_WIDTH-1:0] smallShifted;
	logic [`ALIGN_WIDTH-1:0] lostMask;
	logic stickyOut;

	// Order by magnitude, sign bit left out of the compare
	assign swapOps = addOpA.bits[`HALF_WIDTH-2:0] < addOpB.bits[`HALF_WIDTH-2:0];
	assign bigOp = swapOps ? addOpB : addOpA;
	assign smallOp = swapOps ? addOpA : addOpB;

	// Zero exponent field weighs as exponent one
	assign bigExp = (bigOp.fields.exponent == '0) ? `EXP_WIDTH'(1) : bigOp.fields.exponent;
	assign smallExp = (smallOp.fields.exponent == '0) ? `EXP_WIDTH'(1) : smallOp.fields.exponent;

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= addInValid;
		end
	end

	always_ff @(posedge ap_clk) begin
		s1Sign <= bigOp.fields.sign; // Larger magnitude decides sign
		s1EffSub <= addOpA.fields.sign ^ addOpB.fields.sign;
		s1Exp <= bigExp;
		s1Shift <= bigExp - smallExp; // Never negative after ordering
		s1BigSig <= {|bigOp.fields.exponent, bigOp.fields.mantissa}; // Hidden bit restored
		s1SmallSig <= {|smallOp.fields.exponent, smallOp.fields.mantissa};
	end

	// Three empty bits below the LSB catch G and R
	assign smallExt = {s1SmallSig, 3'b000};
	assign smallShifted = smallExt >> s1Shift;
	assign lostMask = (`ALIGN_WIDTH'(1) << s1Shift) - `ALIGN_WIDTH'(1);
	// Everything past round folds into sticky
	assign stickyOut = (|(smallExt & lostMask)) | smallShifted[0];

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			alignValid <= 1'b0;
		end else begin
			alignValid <= s1Valid;
		end
	end

	always_ff @(posedge ap_clk) begin
		alignedOp.sign <= s1Sign;
		alignedOp.effSub <= s1EffSub;
		alignedOp.exponent <= s1Exp;
		alignedOp.bigSig <= s1BigSig;
		if (s1Shift > (`ALIGN_WIDTH - 1)) begin
			// Shifted clean out, only sticky left
			alignedOp.smallSig <= {{(`ALIGN_WIDTH-1){1'b0}}, |s1SmallSig};
		end else begin
			alignedOp.smallSig <= {smallShifted[`ALIGN_WIDTH-1:1], stickyOut};
		end
	end

endmodule

`default_nettype wire

// File: hw/fpAddNormRound.sv
`timescale 1ns/10ps
`default_nettype none
`include "halfAccum_settings.svh"

module fpAddNormRound (
	input wire ap_clk,
	input wire ap_rst,
	input wire alignValid,
	input wire halfFloatPkg::alignedOp_t alignedOp,
	output logic addOutValid,
	output halfFloatPkg::halfWord_u addResult
);
	import halfFloatPkg::*;

	// Stage three, one spare bit on top for the carry
	logic [`ALIGN_WIDTH:0] bigExt;
	logic [`ALIGN_WIDTH:0] smallExt;
	logic [`ALIGN_WIDTH:0] rawSum;
	logic s3Valid;
	logic s3Sign;
	logic [`EXP_WIDTH-1:0] s3Exp;
	logic [`ALIGN_WIDTH:0] s3Sum;
	logic [3:0] s3Lead; // Zeros above the leading one

	// Stage four
	logic [`ALIGN_WIDTH:0] normSum;
	logic [`EXP_WIDTH+1:0] normExp; // Two extra bits, top one is the borrow
	logic [`MANT_WIDTH-1:0] normMant;
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic [`MANT_WIDTH:0] roundedMant;
	logic [`EXP_WIDTH+1:0] finalExp;
	logic belowNormal;
	halfWord_u resultWord;

	// Leading zero count from the carry bit down
	function automatic logic [3:0] leadZeros(input logic [`ALIGN_WIDTH:0] value);
		logic [3:0] count;
		logic found;
		count = 4'd0;
		found = 1'b0;
		for (int i = `ALIGN_WIDTH; i >= 0; i--) begin
			if (value[i]) begin
				found = 1'b1;
			end else if (!found) begin
				count = count + 4'd1;
			end
		end
		return count;
	endfunction

	assign bigExt = {1'b0, alignedOp.bigSig, 3'b000};
	assign smallExt = {1'b0, alignedOp.smallSig};
	assign rawSum = alignedOp.effSub ? (bigExt - smallExt) : (bigExt + smallExt);

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			s3Valid <= 1'b0;
		end else begin
			s3Valid <= alignValid;
		end
	end

	always_ff @(posedge ap_clk) begin
		s3Sign <= alignedOp.sign;
		s3Exp <= alignedOp.exponent;
		s3Sum <= rawSum;
		s3Lead <= leadZeros(rawSum);
	end

	// Leading one moves up to the carry position
	assign normSum = s3Sum << s3Lead;
	assign normMant = normSum[`ALIGN_WIDTH-1:`ALIGN_WIDTH-`MANT_WIDTH];
	assign guardBit = normSum[3];
	assign roundBit = normSum[2];
	assign stickyBit = |normSum[1:0];
	// Carry out raises by one, each leading zero lowers by one
	assign normExp = (`EXP_WIDTH+2)'(s3Exp) + (`EXP_WIDTH+2)'(1) - (`EXP_WIDTH+2)'(s3Lead);

	// Nearest, ties to even
	assign roundUp = guardBit & (roundBit | stickyBit | normMant[0]);
	assign roundedMant = {1'b0, normMant} + (`MANT_WIDTH+1)'(roundUp);
	assign finalExp = normExp + (`EXP_WIDTH+2)'(roundedMant[`MANT_WIDTH]); // Mantissa wrapped to 0
	assign belowNormal = normExp[`EXP_WIDTH+1] | (normExp == '0);

	always_comb begin
		if (s3Sum == '0) begin
			resultWord.bits = '0; // Exact cancel gives +0
		end else if (belowNormal) begin
			resultWord.fields.sign = s3Sign; // Flush to zero
			resultWord.fields.exponent = '0;
			resultWord.fields.mantissa = '0;
		end else begin
			resultWord.fields.sign = s3Sign;
			resultWord.fields.exponent = finalExp[`EXP_WIDTH-1:0];
			resultWord.fields.mantissa = roundedMant[`MANT_WIDTH-1:0];
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			addOutValid <= 1'b0;
		end else begin
			addOutValid <= s3Valid;
		end
	end

	always_ff @(posedge ap_clk) begin
		addResult <= resultWord;
	end

endmodule

`default_nettype wire

// File: hw/accumCtrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "halfAccum_settings.svh"

module accumCtrl (
	input wire ap_clk,
	input wire ap_rst,
	input wire ap_start,
	input wire ap_continue,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output logic accumResultVld,
	output logic accumInCe0,
	output halfFloatPkg::halfWord_u accumResult,
	output logic [`ACCUM_ADDR_WIDTH-1:0] accumInAddress0,
	input wire halfFloatPkg::halfWord_u accumInQ0,
	output logic addInValid,
	output halfFloatPkg::halfWord_u addOpA,
	output halfFloatPkg::halfWord_u addOpB,
	input wire addOutValid,
	input wire halfFloatPkg::halfWord_u addResult
);
	import halfFloatPkg::*;
	import accumCtrlPkg::*;

	accumState_t state;
	accumState_t nextState;
	logic [`ACCUM_ADDR_WIDTH:0] elemCount; // Also the read address
	halfWord_u runningSum;
	halfWord_u heldResult;
	logic doneLatch; // Set until ap_continue
	logic startAccept;
	logic runDone;

	assign startAccept = (state == stateIdle) && ap_start && !doneLatch;
	// Fetch with all words summed ends the run
	assign runDone = (state == stateFetch) && (elemCount == `ACCUM_COUNT);

	always_comb begin
		nextState = state;
		case (state)
			stateIdle: begin
				if (startAccept) begin
					nextState = stateFetch;
				end
			end
			stateFetch: begin
				nextState = runDone ? stateIdle : stateCapture;
			end
			stateCapture: begin
				nextState = stateWait;
			end
			stateWait: begin
				// Sum returns `FPADD_LATENCY cycles after Capture
				if (addOutValid) begin
					nextState = stateFetch;
				end
			end
			default: begin
				nextState = stateIdle;
			end
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= stateIdle;
			elemCount <= '0;
			doneLatch <= 1'b0;
			heldResult <= '0;
		end else begin
			state <= nextState;
			if (startAccept) begin
				elemCount <= '0;
			end else if (addOutValid) begin
				elemCount <= elemCount + 1'b1; // One element retired
			end
			if (ap_continue) begin
				doneLatch <= 1'b0;
			end else if (runDone) begin
				doneLatch <= 1'b1;
			end
			if (runDone) begin
				heldResult <= runningSum;
			end
		end
	end

	// Running sum starts at +0
	always_ff @(posedge ap_clk) begin
		if (startAccept) begin
			runningSum <= '0;
		end else if (addOutValid) begin
			runningSum <= addResult;
		end
	end

	assign ap_done = runDone | doneLatch;
	assign ap_ready = runDone;
	assign accumResultVld = runDone;
	// Idle only once the last result is taken
	assign ap_idle = (state == stateIdle) && !ap_start && !doneLatch;
	assign accumResult = runDone ? runningSum : heldResult; // Delivered sum visible at once

	// Memory read, data back in Capture
	assign accumInCe0 = (state == stateFetch) && !runDone;
	assign accumInAddress0 = elemCount[`ACCUM_ADDR_WIDTH-1:0];

	// Word goes straight into the adder's first register
	assign addInValid = (state == stateCapture);
	assign addOpA = runningSum;
	assign addOpB = accumInQ0;

endmodule

`default_nettype wire

// File: hw/halfAccum.sv
`timescale 1ns/10ps
`default_nettype none
`include "halfAccum_settings.svh"

module halfAccum (
	input wire ap_clk,
	input wire ap_rst,
	input wire ap_start,
	input wire ap_continue,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output logic accumResultVld,
	output logic accumInCe0,
	output halfFloatPkg::halfWord_u accumResult,
	output logic [`ACCUM_ADDR_WIDTH-1:0] accumInAddress0,
	input wire halfFloatPkg::halfWord_u accumInQ0
);
	import halfFloatPkg::*;

	// Controller to adder
	logic addInValid;
	halfWord_u addOpA; // Running sum
	halfWord_u addOpB; // Memory word
	// Between adder halves
	logic alignValid;
	alignedOp_t alignedOp;
	// Adder back to controller
	logic addOutValid;
	halfWord_u addResult;

	accumCtrl ctrl (
		.ap_clk, .ap_rst, .ap_start, .ap_continue,
		.ap_done, .ap_idle, .ap_ready, .accumResultVld, .accumInCe0,
		.accumResult, .accumInAddress0, .accumInQ0,
		.addInValid, .addOpA, .addOpB, .addOutValid, .addResult
	);

	// Ordering and alignment shift, two cycles
	fpAddAlign addAlign (
		.ap_clk, .ap_rst, .addInValid, .addOpA, .addOpB,
		.alignValid, .alignedOp
	);

	// Add, normalize and round, two cycles
	fpAddNormRound addNorm (
		.ap_clk, .ap_rst, .alignValid, .alignedOp,
		.addOutValid, .addResult
	);

endmodule

`default_nettype wire

// File: verification/halfAccum_properties.sv
`timescale 1ns/10ps
`default_nettype none

module halfAccumProperties (
	input wire ap_clk,
	input wire ap_rst,
	input wire ap_start,
	input wire ap_continue,
	input wire ap_done,
	input wire ap_idle,
	input wire ap_ready,
	input wire accumResultVld,
	input wire accumInCe0
);
	logic running; // Start taken, sum not yet delivered
	int failCount = 0; // Read by the testbench at the end

	// Accept needs Idle and a clear done latch
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			running <= 1'b0;
		end else if (ap_ready) begin
			running <= 1'b0;
		end else if (ap_start && !ap_done && !running) begin
			running <= 1'b1;
		end
	end

	ceInsideRun: assert property (@(posedge ap_clk) disable iff (ap_rst)
		accumInCe0 |-> running)
		else begin
			failCount++;
			$error("Memory read strobe outside a run");
		end

	readyMatchesValid: assert property (@(posedge ap_clk) disable iff (ap_rst)
		ap_ready == accumResultVld)
		else begin
			failCount++;
			$error("ap_ready and accumResultVld differ");
		end

	// Held until the continue cycle
	doneHeld: assert property (@(posedge ap_clk) disable iff (ap_rst)
		(ap_done && !ap_continue) |=> ap_done)
		else begin
			failCount++;
			$error("ap_done dropped without ap_continue");
		end

	idleNotDone: assert property (@(posedge ap_clk) disable iff (ap_rst)
		!(ap_idle && ap_done))
		else begin
			failCount++;
			$error("ap_idle high while ap_done is high");
		end

endmodule

bind halfAccum halfAccumProperties props (
	.ap_clk(ap_clk), .ap_rst(ap_rst), .ap_start(ap_start), .ap_continue(ap_continue),
	.ap_done(ap_done), .ap_idle(ap_idle), .ap_ready(ap_ready),
	.accumResultVld(accumResultVld), .accumInCe0(accumInCe0)
);

`default_nettype wire

// File: verification/halfAccum_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "halfAccum_settings.svh"

module halfAccum_tb;
	import halfFloatPkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RUN_CYCLES = `ACCUM_COUNT * (2 + `FPADD_LATENCY) + 1; // Fetch, Capture, Wait
	localparam int RUN_LIMIT = 10;
	localparam int MARGIN_CYCLES = 200; // Reset, hold window, start and continue cycles

	logic ap_clk;
	logic ap_rst;
	logic ap_start;
	logic ap_continue;
	logic ap_done;
	logic ap_idle;
	logic ap_ready;
	logic accumResultVld;
	logic accumInCe0;
	halfWord_u accumResult;
	logic [`ACCUM_ADDR_WIDTH-1:0] accumInAddress0;
	halfWord_u accumInQ0;

	logic [`HALF_WIDTH-1:0] memWords [0:`ACCUM_COUNT-1];
	int vectorQ [0:`ACCUM_COUNT-1]; // Stimulus in quarter units
	logic [15:0] lfsrState;
	logic [`HALF_WIDTH-1:0] expectedSum;
	logic [`HALF_WIDTH-1:0] lastDelivered; // What accumResult must hold
	int nextAddr;
	logic tbRunning;
	logic holdWindow; // Start held while done is pending
	int errorCount;
	int resultCount;
	int runCount;

	halfAccum UUT (
		.ap_clk(ap_clk), .ap_rst(ap_rst), .ap_start(ap_start), .ap_continue(ap_continue),
		.ap_done(ap_done), .ap_idle(ap_idle), .ap_ready(ap_ready),
		.accumResultVld(accumResultVld), .accumInCe0(accumInCe0), .accumResult(accumResult),
		.accumInAddress0(accumInAddress0), .accumInQ0(accumInQ0)
	);

	initial begin
		ap_clk = 1'b0;
		forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
	end

	// Exact quarter count to half word, nearest with ties to even
	function automatic logic [`HALF_WIDTH-1:0] toHalf(input int q);
		int mag;
		int lead;
		int drop;
		int sig;
		int rem;
		int halfway;
		logic sign;
		sign = (q < 0);
		mag = sign ? -q : q;
		if (mag == 0) begin
			return '0; // Zero is always +0
		end
		lead = 0;
		while ((mag >> (lead + 1)) != 0) begin
			lead++;
		end
		if (lead > `MANT_WIDTH) begin
			drop = lead - `MANT_WIDTH;
			sig = mag >> drop;
			rem = mag & ((1 << drop) - 1);
			halfway = 1 << (drop - 1);
			if (rem > halfway || (rem == halfway && sig[0])) begin
				sig++;
			end
			if (sig == (2 << `MANT_WIDTH)) begin // Carry into next binade
				sig = 1 << `MANT_WIDTH;
				lead++;
			end
		end else begin
			sig = mag << (`MANT_WIDTH - lead);
		end
		// Leading one at 2^(lead-2)
		return {sign, 5'(lead - 2 + `EXP_BIAS), 10'(sig)};
	endfunction

	// Half word back to quarter units
	function automatic int fromHalf(input logic [`HALF_WIDTH-1:0] w);
		int sig;
		int e;
		int mag;
		if (w[14:10] == '0) begin
			return 0;
		end
		sig = (1 << `MANT_WIDTH) + int'(w[9:0]);
		e = int'(w[14:10]);
		mag = (e >= 23) ? (sig << (e - 23)) : (sig >> (23 - e));
		return w[15] ? -mag : mag;
	endfunction

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic takeBits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState); // One step per bit
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic expectLevel(input string name, input logic actual, input logic expected);
		assert (actual === expected) else begin
			errorCount++;
			$display("[ERROR] %0d ns %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	// Memory image and the expected sum, one rounding per add
	task automatic loadVector();
		int runQ;
		runQ = 0;
		for (int i = 0; i < `ACCUM_COUNT; i++) begin
			memWords[i] = toHalf(vectorQ[i]);
			runQ = fromHalf(toHalf(runQ + fromHalf(memWords[i])));
		end
		expectedSum = toHalf(runQ);
	endtask

	task automatic awaitAccept();
		@(negedge ap_clk);
		while (!accumInCe0) begin
			@(negedge ap_clk);
		end
		@(posedge ap_clk);
		ap_start <= 1'b0;
		runCount++;
	endtask

	task automatic startRun();
		@(posedge ap_clk);
		ap_start <= 1'b1;
		awaitAccept();
	endtask

	task automatic waitResult();
		@(negedge ap_clk);
		while (!accumResultVld) begin
			@(negedge ap_clk);
		end
	endtask

	task automatic releaseDone();
		@(posedge ap_clk);
		ap_continue <= 1'b1;
		@(posedge ap_clk);
		ap_continue <= 1'b0;
	endtask

	task automatic runVector();
		loadVector();
		startRun();
		waitResult();
		releaseDone();
	endtask

	// Single-port memory, data one cycle after the strobe
	always @(posedge ap_clk) begin
		if (accumInCe0) begin
			accumInQ0.bits <= memWords[accumInAddress0];
		end
	end

	always @(negedge ap_clk) begin
		if (!ap_rst) begin
			if (accumResultVld) begin
				resultCount++;
				assert (accumResult.bits === expectedSum) else begin
					errorCount++;
					$display("[ERROR] %0d ns accumResult expected %h got %h", $time,
						expectedSum, accumResult.bits);
				end
				lastDelivered = expectedSum;
			end else begin
				assert (accumResult.bits === lastDelivered) else begin // Held between runs
					errorCount++;
					$display("[ERROR] %0d ns accumResult expected %h got %h", $time,
						lastDelivered, accumResult.bits);
				end
			end
		end
	end

	// Read order and the hold window
	always @(negedge ap_clk) begin
		if (ap_rst) begin
			nextAddr = 0;
			tbRunning = 1'b0;
		end else begin
			if (accumInCe0) begin
				assert (nextAddr < `ACCUM_COUNT && int'(accumInAddress0) == nextAddr) else begin
					errorCount++;
					$display("[ERROR] %0d ns accumInAddress0 expected %0d got %0d", $time,
						nextAddr, accumInAddress0);
				end
				nextAddr++;
				tbRunning = 1'b1;
			end
			if (accumResultVld) begin
				assert (nextAddr == `ACCUM_COUNT) else begin
					errorCount++;
					$display("Run ended after %0d memory reads instead of %0d", nextAddr,
						`ACCUM_COUNT);
				end
				nextAddr = 0;
				tbRunning = 1'b0;
			end
			if (holdWindow) begin
				assert (ap_done && !accumInCe0) else begin
					errorCount++;
					$display("Start accepted or ap_done dropped before ap_continue at %0d ns",
						$time);
				end
			end
		end
	end

	idleWhenWaiting: assert property (@(posedge ap_clk) disable iff (ap_rst)
		(!tbRunning && !ap_start && !ap_done) |-> ap_idle)
		else begin
			errorCount++;
			$display("Block waits without a start at %0d ns but ap_idle is low", $time);
		end

	initial begin
		#(CLK_PERIOD * (RUN_LIMIT * RUN_CYCLES + MARGIN_CYCLES));
		$display("Timeout, run did not finish within %0d cycles",
			RUN_LIMIT * RUN_CYCLES + MARGIN_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin : mainSequence
		int value;
		int sign;
		ap_rst = 1'b1;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		accumInQ0 = '0;
		lfsrState = 16'd27;
		expectedSum = '0;
		lastDelivered = '0; // Result register clears on reset
		holdWindow = 1'b0;
		errorCount = 0;
		resultCount = 0;
		runCount = 0;
		repeat (10) @(posedge ap_clk);
		ap_rst <= 1'b0;
		@(negedge ap_clk);
		expectLevel("ap_done", ap_done, 1'b0);
		expectLevel("ap_ready", ap_ready, 1'b0);
		expectLevel("accumResultVld", accumResultVld, 1'b0);
		expectLevel("accumInCe0", accumInCe0, 1'b0);
		expectLevel("ap_idle", ap_idle, 1'b1);

		// Small positive integers
		repeat (2) begin
			for (int i = 0; i < `ACCUM_COUNT; i++) begin
				takeBits(7, value);
				vectorQ[i] = (value % 101) * 4;
			end
			runVector();
		end

		// Signed quarters within 60
		repeat (2) begin
			for (int i = 0; i < `ACCUM_COUNT; i++) begin
				takeBits(8, value);
				takeBits(1, sign);
				vectorQ[i] = sign ? -(value % 241) : (value % 241);
			end
			runVector();
		end
		// Pairs cancel, final sum exactly zero
		for (int i = 0; i < `ACCUM_COUNT; i += 2) begin
			takeBits(8, value);
			takeBits(1, sign);
			vectorQ[i] = sign ? -(value % 241) : (value % 241);
			vectorQ[i + 1] = -vectorQ[i];
		end
		runVector();

		// Ones added at 2048 land halfway between two neighbors
		vectorQ[0] = 2048 * 4;
		for (int i = 1; i < `ACCUM_COUNT; i++) begin
			vectorQ[i] = 4;
		end
		runVector();
		vectorQ[0] = 2050 * 4; // Odd mantissa, first tie rounds up
		runVector();

		// Start held while done is pending
		loadVector();
		startRun();
		waitResult();
		@(posedge ap_clk);
		ap_start <= 1'b1;
		holdWindow <= 1'b1;
		repeat (12) @(posedge ap_clk);
		ap_continue <= 1'b1;
		holdWindow <= 1'b0;
		@(posedge ap_clk);
		ap_continue <= 1'b0;
		awaitAccept(); // Same start now taken
		waitResult();
		releaseDone();

		repeat (4) @(posedge ap_clk);
		assert (resultCount == runCount) else begin
			errorCount++;
			$display("Started %0d runs but saw %0d results", runCount, resultCount);
		end
		$display("Runs %0d, testbench errors %0d, protocol errors %0d", runCount, errorCount,
			UUT.props.failCount);
		if (errorCount == 0 && UUT.props.failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: halfAccum.f
+incdir+hw
hw/halfFloatPkg.sv
hw/accumCtrlPkg.sv
hw/fpAddAlign.sv
hw/fpAddNormRound.sv
hw/accumCtrl.sv
hw/halfAccum.sv
verification/halfAccum_properties.sv
verification/halfAccum_tb.sv
